// ==== verif/kbd_panel_golden.txt ====
# columns: scan code, corrupt parity flag, freeze flag, expected display word
# the word is the state after the frame and any queued codes have drained
1c 0 0 0000001c
32 0 0 00001c32
21 0 0 001c3221
23 0 0 1c322123
2b 0 0 3221232b
34 1 0 3221232b
33 0 0 21232b33
43 0 1 21232b33
3b 0 1 21232b33
42 0 1 21232b33
4b 0 0 433b424b
15 0 1 433b424b
1d 0 1 433b424b
24 0 1 433b424b
2d 0 1 433b424b
2c 0 1 433b424b
35 0 1 433b424b
3c 0 1 433b424b
44 0 1 433b424b
4d 0 1 433b424b
54 0 0 353c4454
5b 0 0 3c44545b
1b 1 0 3c44545b
4c 0 0 44545b4c

// ==== kbd_panel.f ====
+incdir+verif
hw/kbd_pkg.sv
hw/ps2_rx.sv
hw/scan_fifo.sv
hw/key_display.sv
hw/seg_shifter.sv
hw/kbd_panel_top.sv
verif/kbd_panel_checker.sv
verif/kbd_panel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the keyboard panel testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f kbd_panel.f \
    --top-module kbd_panel_tb \
    -o kbd_panel_sim

out=$(./obj_dir/kbd_panel_sim)
echo "$out"

if echo "$out" | grep -q "RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== verif/kbd_panel_expect.svh ====
// testbench check request
`ifndef KBD_PANEL_EXPECT_SVH
`define KBD_PANEL_EXPECT_SVH
`default_nettype none

// one check, filled per golden line
typedef struct packed {
    logic [7:0]  test_id;
    // display word expected after the frame
    logic [31:0] word;
    // sticky flags expected at the same point
    logic        perr;
    logic        ovf;
    // seg frames to let pass before comparing
    logic [1:0]  skip;
} expect_t;

`default_nettype wire
`endif

// ==== verif/kbd_panel_tb.sv ====
// keyboard panel testbench
`timescale 1ns/1ns
`include "kbd_panel_expect.svh"
`default_nettype none

module kbd_panel_tb;

    localparam int          HALF_NS      = 2;
    localparam int          RESET_CYCLES = 8;
    // 40-cycle ps/2 bit period
    localparam int          PS2_HALF     = 20;
    localparam int          ACK_TIMEOUT  = 6000;
    localparam logic [31:0] SEED         = 32'h1f4f41a5;
    localparam string       GOLDEN_PATH  = "verif/kbd_panel_golden.txt";

    logic       clk200m;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    logic [7:0] swt;

    wire [7:0]  leds;
    wire        seg_clk;
    wire        seg_clr;
    wire        seg_dt;
    wire        seg_en;
    wire        kb_overflow;
    wire        kb_parity_err;

    // checker handshake
    logic       check_req;
    expect_t    expected;
    wire        check_ack;
    wire [15:0] pass_cnt;
    wire [15:0] fail_cnt;

    always #(HALF_NS) clk200m = ~clk200m;

    kbd_panel_top kbd_panel_top_i (
        .clk200m       (clk200m),
        .rst           (rst),
        .ps2_clk       (ps2_clk),
        .ps2_data      (ps2_data),
        .swt           (swt),
        .leds          (leds),
        .seg_clk       (seg_clk),
        .seg_clr       (seg_clr),
        .seg_dt        (seg_dt),
        .seg_en        (seg_en),
        .kb_overflow   (kb_overflow),
        .kb_parity_err (kb_parity_err)
    );

    kbd_panel_checker checker_i (
        .clk200m       (clk200m),
        .rst           (rst),
        .leds          (leds),
        .seg_clk       (seg_clk),
        .seg_clr       (seg_clr),
        .seg_dt        (seg_dt),
        .seg_en        (seg_en),
        .kb_overflow   (kb_overflow),
        .kb_parity_err (kb_parity_err),
        .check_req     (check_req),
        .expected      (expected),
        .check_ack     (check_ack),
        .pass_cnt      (pass_cnt),
        .fail_cnt      (fail_cnt)
    );

    // inputs change 1 ns after the rising edge
    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk200m);
        #1;
    endtask

    // start, 8 data lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input logic corrupt);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, (~^code) ^ corrupt, code, 1'b0};
        for (i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            step_cycles(PS2_HALF);
            // keyboard side samples on the falling edge
            ps2_clk = 1'b0;
            step_cycles(PS2_HALF);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic request_check(input expect_t e, output bit ok);
        int n;
        expected  = e;
        check_req = 1'b1;
        ok = 1'b1;
        n = 0;
        while (check_ack !== 1'b1 && n < ACK_TIMEOUT) begin
            step_cycles(1);
            n++;
        end
        if (check_ack !== 1'b1) begin
            $display("checker gave no answer for test %0d", e.test_id);
            ok = 1'b0;
        end else begin
            check_req = 1'b0;
            n = 0;
            while (check_ack !== 1'b0 && n < ACK_TIMEOUT) begin
                step_cycles(1);
                n++;
            end
            if (check_ack !== 1'b0) begin
                $display("checker kept its answer up after test %0d", e.test_id);
                ok = 1'b0;
            end
        end
    endtask

    initial begin
        int          fd;
        int          rc;
        int          fields;
        int          gap;
        int          pending;
        int          tests_run;
        string       line;
        logic [7:0]  code;
        logic        corrupt;
        logic        frozen;
        logic [31:0] word;
        logic        perr_seen;
        logic        ovf_seen;
        bit          ok;
        expect_t     e;
        clk200m   = 1'b0;
        rst       = 1'b1;
        ps2_clk   = 1'b1;
        ps2_data  = 1'b1;
        swt       = '0;
        check_req = 1'b0;
        expected  = '0;
        void'($urandom(SEED));
        perr_seen = 1'b0;
        ovf_seen  = 1'b0;
        pending   = 0;
        step_cycles(RESET_CYCLES);
        rst = 1'b0;
        // reset state gives an all-zero first frame
        e.test_id = 8'd0;
        e.word    = '0;
        e.perr    = 1'b0;
        e.ovf     = 1'b0;
        e.skip    = 2'd1;
        request_check(e, ok);
        tests_run = 1;
        if (ok) begin
            fd = $fopen(GOLDEN_PATH, "r");
            if (fd == 0) begin
                $display("cannot open the golden stimulus file");
                ok = 1'b0;
            end else begin
                while (ok && !$feof(fd)) begin
                    rc = $fgets(line, fd);
                    fields = 0;
                    if (rc > 0 && line[0] != "#") begin
                        fields = $sscanf(line, "%h %h %h %h", code, corrupt, frozen, word);
                    end
                    if (fields == 4) begin
                        gap = 50 + int'($urandom % 151);
                        step_cycles(gap);
                        swt[0] = frozen;
                        send_frame(code, corrupt);
                        // unfreezing drains whatever was queued
                        if (!frozen) begin
                            pending = 0;
                        end
                        if (corrupt) begin
                            perr_seen = 1'b1;
                        end else if (frozen) begin
                            pending++;
                            if (pending > kbd_pkg::FIFO_DEPTH) begin
                                ovf_seen = 1'b1;
                            end
                        end
                        e.test_id = 8'(tests_run);
                        e.word    = word;
                        e.perr    = perr_seen;
                        e.ovf     = ovf_seen;
                        e.skip    = 2'd2;
                        request_check(e, ok);
                        tests_run++;
                    end
                end
                $fclose(fd);
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", tests_run, pass_cnt, fail_cnt);
        if (ok && fail_cnt == 16'd0 && pass_cnt == 16'(tests_run)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/kbd_panel_checker.sv ====
// keyboard panel output checker
`timescale 1ns/1ns
`include "kbd_panel_expect.svh"
`default_nettype none

module kbd_panel_checker (
    input  wire          clk200m,
    input  wire          rst,
    input  wire  [7:0]   leds,
    input  wire          seg_clk,
    input  wire          seg_clr,
    input  wire          seg_dt,
    input  wire          seg_en,
    input  wire          kb_overflow,
    input  wire          kb_parity_err,
    input  wire          check_req,
    input  wire expect_t expected,
    output logic         check_ack,
    output logic [15:0]  pass_cnt,
    output logic [15:0]  fail_cnt
);

    localparam int LEDS_TIMEOUT  = 2000;
    // two seg frames are 522 cycles
    localparam int FRAME_TIMEOUT = 1500;
    localparam int IDLE_TIMEOUT  = 100000;
    localparam int ACK_TIMEOUT   = 100;

    logic                       seg_clk_q;
    logic                       seg_en_q;
    logic [kbd_pkg::DISP_W-1:0] frame_shift;
    logic [kbd_pkg::DISP_W-1:0] frame_word;
    int                         frame_bits;
    int                         frame_len;
    int                         frame_cnt;

    // rebuild frames mid-cycle, outputs settled
    always @(negedge clk200m or posedge rst) begin
        if (rst) begin
            seg_clk_q   <= 1'b0;
            seg_en_q    <= 1'b0;
            frame_shift <= '0;
            frame_word  <= '0;
            frame_bits  <= 0;
            frame_len   <= 0;
            frame_cnt   <= 0;
        end else begin
            seg_clk_q <= seg_clk;
            seg_en_q  <= seg_en;
            if (seg_en && !seg_en_q) begin
                // latch pulse closes the frame
                frame_word <= frame_shift;
                frame_len  <= frame_bits;
                frame_cnt  <= frame_cnt + 1;
                frame_bits <= 0;
            end else if (seg_clk && !seg_clk_q) begin
                // msb first on each rising seg_clk
                frame_shift <= {frame_shift[kbd_pkg::DISP_W-2:0], seg_dt};
                frame_bits  <= frame_bits + 1;
            end
        end
    end

    task automatic run_check();
        expect_t e;
        int      n;
        int      start;
        bit      ok;
        bit      seen;
        e = expected;
        ok = 1'b1;
        // leds settle on the newest code
        n = 0;
        seen = 1'b0;
        while (!seen && n < LEDS_TIMEOUT) begin
            @(negedge clk200m);
            seen = (leds == e.word[7:0]);
            n++;
        end
        if (!seen) begin
            $display("test %0d: leds stayed at %h and never reached %h within %0d cycles",
                     e.test_id, leds, e.word[7:0], LEDS_TIMEOUT);
            ok = 1'b0;
        end
        // earlier frame may predate the update
        start = frame_cnt;
        n = 0;
        while (frame_cnt - start < int'(e.skip) && n < FRAME_TIMEOUT) begin
            @(negedge clk200m);
            n++;
        end
        if (frame_cnt - start < int'(e.skip)) begin
            $display("test %0d: no complete seven-segment frame arrived within %0d cycles",
                     e.test_id, FRAME_TIMEOUT);
            ok = 1'b0;
        end else if (frame_len != kbd_pkg::DISP_W || frame_word !== e.word) begin
            $display("FAIL %0t ns: test %0d seg frame %h with %0d bits, expected %h",
                     $time, e.test_id, frame_word, frame_len, e.word);
            ok = 1'b0;
        end
        if (leds !== e.word[7:0]) begin
            $display("FAIL %0t ns: test %0d leds %h, expected %h",
                     $time, e.test_id, leds, e.word[7:0]);
            ok = 1'b0;
        end
        if (kb_parity_err !== e.perr || kb_overflow !== e.ovf) begin
            $display("FAIL %0t ns: test %0d parity_err %b overflow %b, expected %b %b",
                     $time, e.test_id, kb_parity_err, kb_overflow, e.perr, e.ovf);
            ok = 1'b0;
        end
        if (seg_clr !== 1'b1) begin
            $display("FAIL %0t ns: test %0d seg_clr low after reset", $time, e.test_id);
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt = pass_cnt + 16'd1;
            $display("test %0d passed, word %h", e.test_id, e.word);
        end else begin
            fail_cnt = fail_cnt + 16'd1;
            $display("test %0d failed", e.test_id);
        end
    endtask

    // request and acknowledge with the testbench
    initial begin
        int n;
        check_ack = 1'b0;
        pass_cnt  = '0;
        fail_cnt  = '0;
        forever begin
            n = 0;
            while (check_req !== 1'b1 && n < IDLE_TIMEOUT) begin
                @(negedge clk200m);
                n++;
            end
            if (check_req !== 1'b1) begin
                $display("checker waited %0d cycles and no check was requested", IDLE_TIMEOUT);
                fail_cnt = fail_cnt + 16'd1;
            end else begin
                run_check();
                check_ack = 1'b1;
                n = 0;
                while (check_req !== 1'b0 && n < ACK_TIMEOUT) begin
                    @(negedge clk200m);
                    n++;
                end
                if (check_req !== 1'b0) begin
                    $display("checker request was never withdrawn by the testbench");
                    fail_cnt = fail_cnt + 16'd1;
                end
                check_ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/kbd_panel_top.sv ====
// keyboard panel top level
`timescale 1ns/1ns
`default_nettype none

module kbd_panel_top (
    input  wire       clk200m,
    input  wire       rst,
    input  wire       ps2_clk,
    input  wire       ps2_data,
    input  wire [7:0] swt,
    output wire [7:0] leds,
    output wire       seg_clk,
    output wire       seg_clr,
    output wire       seg_dt,
    output wire       seg_en,
    output wire       kb_overflow,
    output wire       kb_parity_err
);

    // receiver to fifo
    kbd_pkg::code_t rx_code;
    // fifo to display consumer
    kbd_pkg::code_t pop_code;
    logic           empty;
    logic           pop;
    // consumer to serializer
    logic [kbd_pkg::DISP_W-1:0] disp_word;

    ps2_rx ps2_rx_i (
        .clk200m    (clk200m),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .rx_code    (rx_code),
        .parity_err (kb_parity_err)
    );

    scan_fifo scan_fifo_i (
        .clk200m   (clk200m),
        .rst       (rst),
        .push_code (rx_code),
        .pop       (pop),
        .pop_code  (pop_code),
        .empty     (empty),
        .overflow  (kb_overflow)
    );

    // switch 0 holds codes in the fifo
    key_display key_display_i (
        .clk200m   (clk200m),
        .rst       (rst),
        .freeze    (swt[0]),
        .empty     (empty),
        .pop       (pop),
        .pop_code  (pop_code),
        .disp_word (disp_word),
        .leds      (leds)
    );

    seg_shifter seg_shifter_i (
        .clk200m   (clk200m),
        .rst       (rst),
        .disp_word (disp_word),
        .seg_clk   (seg_clk),
        .seg_clr   (seg_clr),
        .seg_dt    (seg_dt),
        .seg_en    (seg_en)
    );

endmodule

`default_nettype wire

// ==== hw/seg_shifter.sv ====
// seven-segment chain serializer
`timescale 1ns/1ns
`default_nettype none

module seg_shifter (
    input  wire                        clk200m,
    input  wire                        rst,
    input  wire [kbd_pkg::DISP_W-1:0]  disp_word,
    output logic                       seg_clk,
    output logic                       seg_clr,
    output logic                       seg_dt,
    output logic                       seg_en
);

    typedef logic [$clog2(kbd_pkg::SEG_HALF)-1:0] div_cnt_t;
    typedef logic [$clog2(2 * kbd_pkg::DISP_W)-1:0] half_cnt_t;

    kbd_pkg::seg_state_e state;
    // cycles within a half period
    div_cnt_t            div_cnt;
    // half periods within the frame, lsb is seg_clk level
    half_cnt_t           half_cnt;
    logic                div_last;

    // frame copy, disp_word may change mid frame
    logic [kbd_pkg::DISP_W-1:0] shadow;

    assign div_last = (div_cnt == div_cnt_t'(kbd_pkg::SEG_HALF - 1));

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state    <= kbd_pkg::SEG_LOAD;
            div_cnt  <= '0;
            half_cnt <= '0;
            seg_clr  <= 1'b0;
        end else begin
            // chain clear released once out of reset
            seg_clr <= 1'b1;
            case (state)
                kbd_pkg::SEG_LOAD: begin
                    div_cnt  <= '0;
                    half_cnt <= '0;
                    state    <= kbd_pkg::SEG_SHIFT;
                end
                kbd_pkg::SEG_SHIFT: begin
                    div_cnt <= div_last ? '0 : div_cnt + 1'b1;
                    if (div_last) begin
                        half_cnt <= half_cnt + 1'b1;
                        if (half_cnt == half_cnt_t'(2 * kbd_pkg::DISP_W - 1)) begin
                            state <= kbd_pkg::SEG_LATCH;
                        end
                    end
                end
                kbd_pkg::SEG_LATCH: begin
                    div_cnt <= div_last ? '0 : div_cnt + 1'b1;
                    if (div_last) begin
                        state <= kbd_pkg::SEG_LOAD;
                    end
                end
                default: begin
                    state <= kbd_pkg::SEG_LOAD;
                end
            endcase
        end
    end

    // msb first, next bit appears as seg_clk falls
    always_ff @(posedge clk200m) begin
        if (state == kbd_pkg::SEG_LOAD) begin
            shadow <= disp_word;
        end else if (state == kbd_pkg::SEG_SHIFT && div_last && half_cnt[0]) begin
            shadow <= {shadow[kbd_pkg::DISP_W-2:0], 1'b0};
        end
    end

    // low half then high half per bit
    assign seg_clk = (state == kbd_pkg::SEG_SHIFT) && half_cnt[0];
    assign seg_dt  = (state == kbd_pkg::SEG_SHIFT) && shadow[kbd_pkg::DISP_W-1];
    assign seg_en  = (state == kbd_pkg::SEG_LATCH);

    // latch pulse never overlaps a shift clock
    a_en_clk_apart: assert property (
        @(posedge clk200m) disable iff (rst) !(seg_en && seg_clk)
    );

endmodule

`default_nettype wire

// ==== hw/key_display.sv ====
// scan code display consumer
`timescale 1ns/1ns
`default_nettype none

module key_display (
    input  wire                          clk200m,
    input  wire                          rst,
    input  wire                          freeze,
    input  wire                          empty,
    output logic                         pop,
    input  wire                          kbd_pkg::code_t pop_code,
    output logic [kbd_pkg::DISP_W-1:0]   disp_word,
    output logic [7:0]                   leds
);

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            pop       <= 1'b0;
            disp_word <= '0;
        end else begin
            // one pop in flight at a time
            // empty is fresh again one cycle after a pop
            pop <= !freeze && !empty && !pop;
            // oldest code falls off the top byte
            if (pop_code.valid) begin
                disp_word <= {disp_word[kbd_pkg::DISP_W-kbd_pkg::CODE_W-1:0],
                              pop_code.code};
            end
        end
    end

    // leds show the newest code
    assign leds = disp_word[kbd_pkg::CODE_W-1:0];

    // fifo answers each pop exactly one cycle later
    a_pop_answer: assert property (
        @(posedge clk200m) disable iff (rst) pop |=> pop_code.valid
    );

    a_no_stray_data: assert property (
        @(posedge clk200m) disable iff (rst) pop_code.valid |-> $past(pop)
    );

endmodule

`default_nettype wire

// ==== hw/scan_fifo.sv ====
// scan code fifo
`timescale 1ns/1ns
`default_nettype none

module scan_fifo (
    input  wire            clk200m,
    input  wire            rst,
    input  wire            kbd_pkg::code_t push_code,
    input  wire            pop,
    output kbd_pkg::code_t pop_code,
    output logic           empty,
    output logic           overflow
);

    typedef logic [kbd_pkg::FIFO_AW:0] cnt_t;

    logic [kbd_pkg::CODE_W-1:0] mem [kbd_pkg::FIFO_DEPTH];
    logic [kbd_pkg::FIFO_AW-1:0] wr_ptr;
    logic [kbd_pkg::FIFO_AW-1:0] rd_ptr;
    cnt_t                        count;
    cnt_t                        count_nxt;

    logic                       full;
    logic                       do_push;
    logic                       do_pop;
    logic [kbd_pkg::CODE_W-1:0] pop_data;
    logic                       pop_valid;

    assign full    = (count == cnt_t'(kbd_pkg::FIFO_DEPTH));
    // codes arriving while full are lost
    assign do_push = push_code.valid && !full;
    assign do_pop  = pop && !empty;

    always_comb begin
        count_nxt = count;
        if (do_push && !do_pop) begin
            count_nxt = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            empty     <= 1'b1;
            overflow  <= 1'b0;
            pop_valid <= 1'b0;
        end else begin
            count     <= count_nxt;
            // registered flag follows the updated count
            empty     <= (count_nxt == '0);
            pop_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky until reset
            if (push_code.valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // storage and read data
    always_ff @(posedge clk200m) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code.code;
        end
        if (do_pop) begin
            pop_data <= mem[rd_ptr];
        end
    end

    assign pop_code.code  = pop_data;
    assign pop_code.valid = pop_valid;

    // consumer must respect empty
    a_no_pop_empty: assert property (
        @(posedge clk200m) disable iff (rst) pop |-> !empty
    );

    a_count_bound: assert property (
        @(posedge clk200m) disable iff (rst) count <= cnt_t'(kbd_pkg::FIFO_DEPTH)
    );

endmodule

`default_nettype wire

// ==== hw/ps2_rx.sv ====
// ps/2 keyboard receiver
`timescale 1ns/1ns
`default_nettype none

module ps2_rx (
    input  wire            clk200m,
    input  wire            rst,
    input  wire            ps2_clk,
    input  wire            ps2_data,
    output kbd_pkg::code_t rx_code,
    output logic           parity_err
);

    typedef logic [$clog2(kbd_pkg::PS2_TIMEOUT)-1:0] tmo_cnt_t;
    typedef logic [$clog2(kbd_pkg::CODE_W)-1:0] bit_cnt_t;

    // two-flop synchronizers, lines idle high
    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       fall;

    kbd_pkg::rx_state_e state;
    bit_cnt_t           bit_cnt;
    tmo_cnt_t           idle_cnt;

    // frame payload
    logic [kbd_pkg::CODE_W-1:0] shreg;
    logic                       par_bit;
    logic                       frame_ok;
    logic                       valid_q;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    // falling edge of the synchronized ps/2 clock
    assign fall = clk_prev & ~clk_sync[1];

    // stop bit high and odd parity over data plus parity bit
    assign frame_ok = data_sync[1] & (^{shreg, par_bit});

    // data bits arrive lsb first
    always_ff @(posedge clk200m) begin
        if (fall && state == kbd_pkg::RX_DATA) begin
            shreg <= {data_sync[1], shreg[kbd_pkg::CODE_W-1:1]};
        end
        if (fall && state == kbd_pkg::RX_PARITY) begin
            par_bit <= data_sync[1];
        end
    end

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state      <= kbd_pkg::RX_IDLE;
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            valid_q    <= 1'b0;
            parity_err <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            // idle counter only runs inside a frame
            if (fall || state == kbd_pkg::RX_IDLE) begin
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
            if (fall) begin
                case (state)
                    kbd_pkg::RX_IDLE: begin
                        // low data on the first edge is the start bit
                        if (!data_sync[1]) begin
                            state   <= kbd_pkg::RX_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    kbd_pkg::RX_DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_cnt_t'(kbd_pkg::CODE_W - 1)) begin
                            state <= kbd_pkg::RX_PARITY;
                        end
                    end
                    kbd_pkg::RX_PARITY: begin
                        state <= kbd_pkg::RX_STOP;
                    end
                    kbd_pkg::RX_STOP: begin
                        // bad frames only raise the sticky flag
                        if (frame_ok) begin
                            valid_q <= 1'b1;
                        end else begin
                            parity_err <= 1'b1;
                        end
                        state <= kbd_pkg::RX_IDLE;
                    end
                    default: begin
                        state <= kbd_pkg::RX_IDLE;
                    end
                endcase
            end else if (idle_cnt == tmo_cnt_t'(kbd_pkg::PS2_TIMEOUT - 1)) begin
                // keyboard went quiet mid frame
                state <= kbd_pkg::RX_IDLE;
            end
        end
    end

    // shreg holds until the next frame's data bits
    assign rx_code.code  = shreg;
    assign rx_code.valid = valid_q;

    // one code per frame, frames are far longer than two cycles
    a_single_strobe: assert property (
        @(posedge clk200m) disable iff (rst) rx_code.valid |=> !rx_code.valid
    );

endmodule

`default_nettype wire

// ==== hw/kbd_pkg.sv ====
// keyboard panel shared definitions
`default_nettype none

package kbd_pkg;

    // scan code width, one ps/2 data byte
    localparam int CODE_W = 8;

    // display word, the last four codes
    localparam int DISP_W = 32;

    // scan code fifo geometry
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = 3;

    // clk200m cycles per seg_clk half period
    localparam int SEG_HALF = 4;

    // cycles without a ps/2 falling edge before a partial frame is dropped
    localparam int PS2_TIMEOUT = 4096;

    // one scan code, valid is a single-cycle strobe
    typedef struct packed {
        logic [CODE_W-1:0] code;
        logic              valid;
    } code_t;

    // receiver states
    // start bit is taken in RX_IDLE
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    // serializer states
    typedef enum logic [1:0] {
        SEG_LOAD,
        SEG_SHIFT,
        SEG_LATCH
    } seg_state_e;

endpackage

`default_nettype wire
